/* build.f */
+incdir+src
src/rs_pkg.sv
src/rs_entry_if.sv
src/rs_alloc.sv
src/rs_entry.sv
src/rs_select.sv
src/rs_alu_station.sv
test/tb_clock_gen.sv
test/tb_rs_alu_station.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the reservation station testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_rs_alu_station -Mdir "$BUILD_DIR" -o sim_rs
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_rs" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* test/tb_rs_alu_station.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module tb_rs_alu_station;
    import rs_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic        clk;
    logic        arst_n;
    logic        disp_valid;
    logic        disp_ready;
    rs_payload_t disp_payload;
    logic        disp_src1_rdy;
    logic        disp_src2_rdy;
    logic        wake_valid [`RS_WAKE_PORTS];
    phys_tag_t   wake_tag [`RS_WAKE_PORTS];
    logic        flush;
    logic        issue_valid;
    logic        issue_ready;
    rs_payload_t issue_payload;

    logic [15:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;
    rs_payload_t issued_q [$]; // packets that left the issue port
    rs_payload_t expected_q [$];

    tb_clock_gen i_tb_clock_gen (.clk(clk), .arst_n(arst_n));

    rs_alu_station i_rs_alu_station (
        .clk           (clk),
        .arst_n        (arst_n),
        .disp_valid    (disp_valid),
        .disp_ready    (disp_ready),
        .disp_payload  (disp_payload),
        .disp_src1_rdy (disp_src1_rdy),
        .disp_src2_rdy (disp_src2_rdy),
        .wake_valid    (wake_valid),
        .wake_tag      (wake_tag),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_payload (issue_payload)
    );

    always @(posedge clk) begin
        if (arst_n && issue_valid && issue_ready) issued_q.push_back(issue_payload);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic rs_payload_t random_payload();
        rs_payload_t p;
        logic [31:0] v;
        v = rand_bits(`RS_ROB_W);
        p.rob_id = v[`RS_ROB_W-1:0];
        p.pc = rand_bits(`RS_XLEN);
        v = rand_bits(`RS_TAG_W);
        p.rd = v[`RS_TAG_W-1:0];
        v = rand_bits(4);
        p.op = alu_op_e'(v[3:0] % 4'd12); // only the twelve defined opcodes
        v = rand_bits(2);
        p.src1_sel = v[1];
        p.src2_sel = v[0];
        p.imm = rand_bits(`RS_XLEN);
        v = rand_bits(2 * `RS_TAG_W);
        p.src1 = v[2*`RS_TAG_W-1:`RS_TAG_W];
        p.src2 = v[`RS_TAG_W-1:0];
        return p;
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic check_payload(input string name, input rs_payload_t actual,
                                 input rs_payload_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        disp_valid = 1'b0;
        for (int p = 0; p < `RS_WAKE_PORTS; p++) wake_valid[p] = 1'b0;
    endtask

    // returns on the falling edge before the transfer edge
    task automatic dispatch(input rs_payload_t p, input logic rdy1, input logic rdy2);
        int n;
        @(negedge clk);
        disp_valid    = 1'b1;
        disp_payload  = p;
        disp_src1_rdy = rdy1;
        disp_src2_rdy = rdy2;
        n = 0;
        while (!disp_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!disp_ready) report_timeout("disp_ready");
    endtask

    task automatic broadcast(input int port, input phys_tag_t tag);
        @(negedge clk);
        wake_valid[port] = 1'b1;
        wake_tag[port]   = tag;
        idle_inputs();
    endtask

    task automatic expect_issue(input rs_payload_t exp);
        int n;
        n = 0;
        while (issued_q.size() == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (issued_q.size() == 0) report_timeout("an issued micro-op");
        else check_payload("issue_payload", issued_q.pop_front(), exp);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        checks++;
        if (issued_q.size() != 0) begin
            errors++;
            $display("a micro-op issued when none was expected");
            issued_q.delete();
        end
    endtask

    task automatic test_reset();
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("disp_ready", disp_ready, 1'b1);
    endtask

    task automatic test_in_order();
        rs_payload_t ops [6];
        foreach (ops[i]) ops[i] = random_payload();
        foreach (ops[i]) dispatch(ops[i], 1'b1, 1'b1);
        idle_inputs();
        foreach (ops[i]) expect_issue(ops[i]);
    endtask

    task automatic test_wakeup();
        rs_payload_t a;
        rs_payload_t b;
        rs_payload_t c;
        a = random_payload();
        a.src1_sel = 1'b0;
        a.src1 = 8'h31;
        dispatch(a, 1'b0, 1'b1);
        idle_inputs();
        expect_quiet(5);
        broadcast(2, 8'h31);
        expect_issue(a);
        b = random_payload(); // pc and immediate operands
        b.src1_sel = 1'b1;
        b.src2_sel = 1'b1;
        dispatch(b, 1'b0, 1'b0);
        idle_inputs();
        expect_issue(b);
        c = random_payload();
        c.src2_sel = 1'b0;
        c.src2 = 8'h52;
        dispatch(c, 1'b1, 1'b0);
        wake_valid[1] = 1'b1; // completes in the dispatch cycle
        wake_tag[1]   = 8'h52;
        idle_inputs();
        expect_issue(c);
    endtask

    task automatic test_younger_first();
        rs_payload_t d;
        rs_payload_t e;
        d = random_payload();
        d.src2_sel = 1'b0;
        d.src2 = 8'h63;
        e = random_payload();
        dispatch(d, 1'b1, 1'b0);
        dispatch(e, 1'b1, 1'b1);
        idle_inputs();
        expect_issue(e);
        expect_quiet(3);
        broadcast(0, 8'h63);
        expect_issue(d);
    endtask

    task automatic test_backpressure();
        rs_payload_t p;
        int n;
        @(negedge clk);
        issue_ready = 1'b0;
        expected_q.delete();
        n = 0;
        while (disp_ready && n < 2 * `RS_DEPTH) begin
            p = random_payload();
            disp_valid    = 1'b1;
            disp_payload  = p;
            disp_src1_rdy = 1'b1;
            disp_src2_rdy = 1'b1;
            expected_q.push_back(p);
            if (issue_valid) check_payload("issue_payload", issue_payload, expected_q[0]);
            @(negedge clk);
            n++;
        end
        disp_valid = 1'b0;
        if (disp_ready) report_timeout("disp_ready to drop");
        // the oldest sits in the issue register, the rest fill every slot
        check_count("accepted dispatches", expected_q.size(), `RS_DEPTH + 1);
        repeat (4) begin
            @(negedge clk);
            check_bit("issue_valid", issue_valid, 1'b1);
            check_bit("disp_ready", disp_ready, 1'b0);
            check_payload("issue_payload", issue_payload, expected_q[0]);
        end
        issue_ready = 1'b1;
        while (expected_q.size() > 0) expect_issue(expected_q.pop_front());
    endtask

    task automatic test_flush();
        rs_payload_t w;
        rs_payload_t f;
        phys_tag_t   tags [$];
        int          n;
        @(negedge clk);
        issue_ready = 1'b0; // first micro-op parks in the issue register
        dispatch(random_payload(), 1'b1, 1'b1);
        n = 0;
        @(negedge clk);
        while (disp_ready && n < 2 * `RS_DEPTH) begin
            w = random_payload();
            w.src1_sel = 1'b0;
            w.src1 = 8'h71 + n[7:0];
            tags.push_back(w.src1);
            disp_valid    = 1'b1;
            disp_payload  = w;
            disp_src1_rdy = 1'b0;
            disp_src2_rdy = 1'b1;
            @(negedge clk);
            n++;
        end
        disp_valid = 1'b0;
        check_bit("issue_valid", issue_valid, 1'b1);
        check_bit("disp_ready", disp_ready, 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        issue_ready = 1'b1;
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("disp_ready", disp_ready, 1'b1);
        foreach (tags[i]) broadcast(i % `RS_WAKE_PORTS, tags[i]);
        expect_quiet(10);
        f = random_payload();
        dispatch(f, 1'b1, 1'b1);
        idle_inputs();
        expect_issue(f);
    endtask

    initial begin
        int n;
        lfsr_state    = 16'd14658;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        disp_valid    = 1'b0;
        disp_payload  = '0;
        disp_src1_rdy = 1'b0;
        disp_src2_rdy = 1'b0;
        flush         = 1'b0;
        issue_ready   = 1'b1;
        for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
            wake_valid[p] = 1'b0;
            wake_tag[p]   = '0;
        end
        n = 0;
        while (arst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1) report_timeout("reset release");
        @(negedge clk);
        test_reset();
        test_in_order();
        test_wakeup();
        test_younger_first();
        test_backpressure();
        test_flush();
        $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // held low for four full periods, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* src/rs_alu_station.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_alu_station (
    input  logic                clk,
    input  logic                arst_n,
    // dispatch from rename
    input  logic                disp_valid,
    output logic                disp_ready,
    input  rs_pkg::rs_payload_t disp_payload,
    input  logic                disp_src1_rdy,
    input  logic                disp_src2_rdy,
    // completion broadcasts
    input  logic                wake_valid [`RS_WAKE_PORTS],
    input  rs_pkg::phys_tag_t   wake_tag [`RS_WAKE_PORTS],
    input  logic                flush,
    // issue to the alu
    output logic                issue_valid,
    input  logic                issue_ready,
    output rs_pkg::rs_payload_t issue_payload
);

    rs_entry_if ents [`RS_DEPTH] ();

    rs_alloc i_rs_alloc (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .disp_valid    (disp_valid),
        .disp_ready    (disp_ready),
        .disp_payload  (disp_payload),
        .disp_src1_rdy (disp_src1_rdy),
        .disp_src2_rdy (disp_src2_rdy),
        .wake_valid    (wake_valid),
        .wake_tag      (wake_tag),
        .ents          (ents)
    );

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_slot
        rs_entry i_rs_entry (
            .clk        (clk),
            .arst_n     (arst_n),
            .flush      (flush),
            .wake_valid (wake_valid),
            .wake_tag   (wake_tag),
            .port       (ents[i])
        );
    end

    rs_select i_rs_select (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .ents          (ents),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_payload (issue_payload)
    );

endmodule

`default_nettype wire

/* src/rs_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_select (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    rs_entry_if.select          ents [`RS_DEPTH],
    output logic                issue_valid,
    input  logic                issue_ready,
    output rs_pkg::rs_payload_t issue_payload
);
    import rs_pkg::*;

    logic [`RS_IDX_W-1:0] head;
    logic [`RS_DEPTH-1:0] busy_vec;
    logic [`RS_DEPTH-1:0] ready_vec;
    rs_payload_t          pay_arr [`RS_DEPTH];
    logic                 pick_found;
    logic [`RS_IDX_W-1:0] pick_idx;
    logic                 load;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_ent
        localparam logic [`RS_IDX_W-1:0] idx = i;

        assign busy_vec[i]   = ents[i].busy;
        assign ready_vec[i]  = ents[i].ready;
        assign pay_arr[i]    = ents[i].payload;
        assign ents[i].clear = load && (pick_idx == idx);
    end

    // first ready slot counting from head
    always_comb begin : pick_oldest
        logic [`RS_IDX_W-1:0] slot;
        pick_found = 1'b0;
        pick_idx   = head;
        for (int k = 0; k < `RS_WINDOW; k++) begin
            slot = head + k[`RS_IDX_W-1:0];
            if (!pick_found && ready_vec[slot]) begin
                pick_found = 1'b1;
                pick_idx   = slot;
            end
        end
    end

    // output register empty or draining this cycle
    assign load = pick_found && (!issue_valid || issue_ready) && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
        end else if (flush) begin
            head <= '0;
        end else if (!busy_vec[head] && |busy_vec) begin
            head <= head + 1'b1; // skip a hole left by out-of-order issue
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else if (flush) begin
            issue_valid <= 1'b0;
        end else if (load) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) issue_payload <= pay_arr[pick_idx];
    end

    // a picked slot is released on the load edge, so it cannot issue twice
    a_pick_released: assert property (@(posedge clk) disable iff (!arst_n)
        load |=> !busy_vec[$past(pick_idx)]);

endmodule

`default_nettype wire

/* src/rs_entry.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_entry (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              wake_valid [`RS_WAKE_PORTS],
    input  rs_pkg::phys_tag_t wake_tag [`RS_WAKE_PORTS],
    rs_entry_if.entry         port
);
    import rs_pkg::*;

    entry_state_e state;
    rs_payload_t  payload_q;
    logic         src1_ok;
    logic         src2_ok;
    logic         hit1;
    logic         hit2;

    // compare held source tags against every broadcast
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
            if (wake_valid[p] && wake_tag[p] == payload_q.src1) begin
                hit1 = 1'b1;
            end
            if (wake_valid[p] && wake_tag[p] == payload_q.src2) begin
                hit2 = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_empty;
            src1_ok <= 1'b0;
            src2_ok <= 1'b0;
        end else if (flush || port.clear) begin
            state <= st_empty;
        end else if (port.alloc_we) begin
            src1_ok <= port.alloc_rdy1;
            src2_ok <= port.alloc_rdy2;
            state   <= (port.alloc_rdy1 && port.alloc_rdy2) ? st_ready : st_wait;
        end else if (state == st_wait) begin
            if (hit1) src1_ok <= 1'b1;
            if (hit2) src2_ok <= 1'b1;
            if ((src1_ok || hit1) && (src2_ok || hit2)) begin
                state <= st_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.alloc_we) payload_q <= port.alloc_payload;
    end

    assign port.busy    = (state != st_empty);
    assign port.ready   = (state == st_ready);
    assign port.payload = payload_q;

    a_clear_when_ready: assert property (@(posedge clk) disable iff (!arst_n)
        port.clear |-> state == st_ready);

endmodule

`default_nettype wire

/* src/rs_alloc.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_alloc (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  rs_pkg::rs_payload_t disp_payload,
    input  logic                disp_src1_rdy,
    input  logic                disp_src2_rdy,
    input  logic                wake_valid [`RS_WAKE_PORTS],
    input  rs_pkg::phys_tag_t   wake_tag [`RS_WAKE_PORTS],
    rs_entry_if.alloc           ents [`RS_DEPTH]
);

    logic [`RS_IDX_W-1:0] tail;
    logic [`RS_DEPTH-1:0] busy_vec;
    logic                 xfer;
    logic                 bypass1;
    logic                 bypass2;
    logic                 rdy1;
    logic                 rdy2;

    // tag completing in the same cycle as its dispatch
    always_comb begin
        bypass1 = 1'b0;
        bypass2 = 1'b0;
        for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
            if (wake_valid[p] && wake_tag[p] == disp_payload.src1) begin
                bypass1 = 1'b1;
            end
            if (wake_valid[p] && wake_tag[p] == disp_payload.src2) begin
                bypass2 = 1'b1;
            end
        end
    end

    assign rdy1 = disp_payload.src1_sel || disp_src1_rdy || bypass1;
    assign rdy2 = disp_payload.src2_sel || disp_src2_rdy || bypass2;

    assign disp_ready = ~busy_vec[tail]; // full when the tail slot is still held
    assign xfer       = disp_valid && disp_ready;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_ent
        localparam logic [`RS_IDX_W-1:0] idx = i;

        assign busy_vec[i]           = ents[i].busy;
        assign ents[i].alloc_we      = xfer && (tail == idx);
        assign ents[i].alloc_payload = disp_payload;
        assign ents[i].alloc_rdy1    = rdy1;
        assign ents[i].alloc_rdy2    = rdy2;

        // the written slot holds the micro-op from the next edge
        a_write_lands: assert property (@(posedge clk) disable iff (!arst_n)
            ents[i].alloc_we && !flush |=> busy_vec[i]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail <= '0;
        end else if (flush) begin
            tail <= '0;
        end else if (xfer) begin
            tail <= tail + 1'b1; // ring wraps on its own
        end
    end

endmodule

`default_nettype wire

/* src/rs_entry_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface rs_entry_if;
    import rs_pkg::*;

    // allocator side
    logic        alloc_we;
    rs_payload_t alloc_payload;
    logic        alloc_rdy1;
    logic        alloc_rdy2;

    // slot status
    logic        busy;
    logic        ready;
    rs_payload_t payload;

    logic        clear; // selector took this slot

    modport alloc (
        output alloc_we, alloc_payload, alloc_rdy1, alloc_rdy2,
        input  busy
    );

    modport entry (
        input  alloc_we, alloc_payload, alloc_rdy1, alloc_rdy2, clear,
        output busy, ready, payload
    );

    modport select (
        input  busy, ready, payload,
        output clear
    );

endinterface

`default_nettype wire

/* src/rs_pkg.sv */
`default_nettype none

`include "rs_params.svh"

package rs_pkg;

    typedef logic [`RS_TAG_W-1:0] phys_tag_t;
    typedef logic [`RS_ROB_W-1:0] rob_id_t;

    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        sll    = 4'd2,
        slt    = 4'd3,
        sltu   = 4'd4,
        xor_op = 4'd5,
        srl    = 4'd6,
        sra    = 4'd7,
        or_op  = 4'd8,
        and_op = 4'd9,
        lui    = 4'd10,
        auipc  = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        st_empty = 2'd0,
        st_wait  = 2'd1,
        st_ready = 2'd2
    } entry_state_e;

    // dispatch payload, also the issue packet
    typedef struct packed {
        rob_id_t            rob_id;
        logic [`RS_XLEN-1:0] pc;
        phys_tag_t          rd;
        alu_op_e            op;
        logic               src1_sel; // 1: operand a is the pc
        logic               src2_sel; // 1: operand b is the immediate
        logic [`RS_XLEN-1:0] imm;
        phys_tag_t          src1;
        phys_tag_t          src2;
    } rs_payload_t;

endpackage

`default_nettype wire

/* src/rs_params.svh */
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// station geometry
`define RS_DEPTH 16
`define RS_IDX_W 4

// entries from head that the selector looks at
`define RS_WINDOW 4

// payload widths
`define RS_TAG_W 8
`define RS_ROB_W 6
`define RS_XLEN 32

// completion broadcast ports
`define RS_WAKE_PORTS 4

`endif
